// ==== files.f ====
logic/jtag_pkg.sv
logic/dbg_pkg.sv
logic/jtag_tap_fsm.sv
logic/jtag_bit_counter.sv
logic/jtag_ir.sv
logic/jtag_dr_bank.sv
logic/jtag.sv
tests/jtag_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= jtag_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) && echo "test passed" || (echo "test failed"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/jtag_tb.sv ====
`default_nettype none
`timescale 1ns/100ps

module jtag_tb;
	localparam int HALF_PERIOD = 8;
	localparam int TIMEOUT = 64;
	localparam int NUM_ROWS = 10;

	typedef struct packed {
		logic [3:0]  op;
		int          ir_len;
		int          dr_len;
		logic [63:0] wdata;
		logic [31:0] stat;
		logic [63:0] exp_ir_tdo;
		logic [63:0] exp_tdo;
		logic [31:0] exp_cfg;
	} scan_row_t;

	logic clk;
	logic arst_n_i;
	logic tck_i;
	logic tms_i;
	logic tdi_i;
	logic trst_n_i;
	logic tdo_o;
	logic tdo_en_o;
	dbg_pkg::dbg_stat_t stat_i;
	dbg_pkg::dbg_cfg_t cfg_o;
	dbg_pkg::dbg_cfg_t cfg_default;
	scan_row_t rows [NUM_ROWS];
	logic [63:0] seen;

	jtag UUT (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.tck_i    (tck_i),
		.tms_i    (tms_i),
		.tdi_i    (tdi_i),
		.trst_n_i (trst_n_i),
		.tdo_o    (tdo_o),
		.tdo_en_o (tdo_en_o),
		.stat_i   (stat_i),
		.cfg_o    (cfg_o)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic fail_and_stop();
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (expected !== actual) begin
			$display("[FAIL] %s expected 0x%0h actual 0x%0h", name, expected, actual);
			fail_and_stop();
		end
	endtask

	task automatic wait_tdo_en(input logic want);
		int n;
		n = 0;
		while ((tdo_en_o !== want) && (n < TIMEOUT)) begin
			@(negedge clk);
			n++;
		end
		if (tdo_en_o !== want) begin
			$display("Timeout: tdo_en_o did not become %0b within %0d clk cycles",
				want, TIMEOUT);
			fail_and_stop();
		end
	endtask

	// TMS and TDI change with tck low, half a period before the rising edge
	task automatic tck_low(input logic tms, input logic tdi);
		tck_i = 1'b0;
		tms_i = tms;
		tdi_i = tdi;
		repeat (HALF_PERIOD) @(negedge clk);
	endtask

	task automatic tck_high();
		tck_i = 1'b1;
		repeat (HALF_PERIOD) @(negedge clk);
	endtask

	task automatic tck_step(input logic tms);
		tck_low(tms, 1'b0);
		tck_high();
	endtask

	// Run-Test/Idle through one IR or DR scan and back to Run-Test/Idle
	task automatic scan(input logic is_ir, input logic [63:0] data, input int len,
			input logic [31:0] stat_next, output logic [63:0] tdo_bits);
		int k;
		tdo_bits = '0;
		tck_step(1'b1);
		if (is_ir) begin
			tck_step(1'b1);
		end
		tck_step(1'b0);
		tck_step(1'b0);
		// Capture done so later stat values stay out of the scan
		stat_i = stat_next;
		for (k = 0; k < len; k++) begin
			tck_low(k == len - 1, data[k]);
			wait_tdo_en(1'b1);
			tdo_bits[k] = tdo_o;
			tck_high();
		end
		// Exit1 then Update
		tck_low(1'b1, 1'b0);
		wait_tdo_en(1'b0);
		tck_high();
		tck_step(1'b0);
	endtask

	// Captured bits leave first, then the TDI bits that followed them
	function automatic logic [63:0] shift_out(input logic [63:0] captured, input int width,
			input logic [63:0] data, input int len);
		logic [63:0] bits;
		int k;
		bits = '0;
		for (k = 0; k < len; k++) begin
			bits[k] = (k < width) ? captured[k] : data[k - width];
		end
		return bits;
	endfunction

	task automatic build_table();
		logic [3:0] codes [NUM_ROWS];
		int ir_lens [NUM_ROWS];
		int dr_lens [NUM_ROWS];
		logic [3:0] op;
		logic [31:0] cfg;
		logic [63:0] captured;
		int width;
		int i;
		codes = '{4'hF, 4'hA, jtag_pkg::OP_CFG_WR, jtag_pkg::OP_CFG_RD, jtag_pkg::OP_CFG_WR,
			jtag_pkg::OP_CFG_WR, jtag_pkg::OP_STAT_RD, jtag_pkg::OP_STAT_RD,
			jtag_pkg::OP_CFG_RD, jtag_pkg::OP_IDCODE};
		ir_lens = '{4, 4, 4, 4, 4, 4, 3, 4, 4, 4};
		dr_lens = '{16, 12, 32, 32, 31, 33, 32, 32, 32, 32};
		op = jtag_pkg::OP_IDCODE;
		cfg = cfg_default;
		for (i = 0; i < NUM_ROWS; i++) begin
			rows[i].op = codes[i];
			rows[i].ir_len = ir_lens[i];
			rows[i].dr_len = dr_lens[i];
			rows[i].wdata = {$urandom, $urandom};
			rows[i].stat = $urandom;
			rows[i].exp_ir_tdo = shift_out(64'h1, jtag_pkg::IR_WIDTH, {60'h0, codes[i]},
				ir_lens[i]);
			if (ir_lens[i] == jtag_pkg::IR_WIDTH) begin
				op = codes[i];
			end
			width = jtag_pkg::DR_WIDTH;
			case (op)
				jtag_pkg::OP_IDCODE:  captured = {32'h0, jtag_pkg::IDCODE_VALUE};
				jtag_pkg::OP_CFG_WR:  captured = {32'h0, cfg};
				jtag_pkg::OP_CFG_RD:  captured = {32'h0, cfg};
				jtag_pkg::OP_STAT_RD: captured = {32'h0, rows[i].stat};
				default: begin
					captured = '0;
					width = 1;
				end
			endcase
			rows[i].exp_tdo = shift_out(captured, width, rows[i].wdata, dr_lens[i]);
			if ((op == jtag_pkg::OP_CFG_WR) && (dr_lens[i] == jtag_pkg::DR_WIDTH)) begin
				cfg = rows[i].wdata[31:0];
			end
			rows[i].exp_cfg = cfg;
		end
	endtask

	initial begin
		int i;
		void'($urandom(19));
		arst_n_i = 1'b0;
		tck_i = 1'b0;
		tms_i = 1'b1;
		tdi_i = 1'b0;
		trst_n_i = 1'b1;
		stat_i = '0;
		// All three core resets asserted
		cfg_default = '0;
		cfg_default.ki = 4'd2;
		cfg_default.kp = 4'd4;
		repeat (4) @(negedge clk);
		arst_n_i = 1'b1;
		@(negedge clk);

		check_value("cfg_o", {32'h0, cfg_default}, {32'h0, cfg_o});
		check_value("tdo_en_o", 64'h0, {63'h0, tdo_en_o});
		check_value("tdo_o", 64'h0, {63'h0, tdo_o});
		tck_step(1'b0);
		scan(1'b0, {$urandom, $urandom}, 32, stat_i, seen);
		check_value("tdo_o", {32'h0, jtag_pkg::IDCODE_VALUE}, seen);
		check_value("cfg_o", {32'h0, cfg_default}, {32'h0, cfg_o});

		build_table();
		for (i = 0; i < NUM_ROWS; i++) begin
			scan(1'b1, {60'h0, rows[i].op}, rows[i].ir_len, stat_i, seen);
			check_value("tdo_o", rows[i].exp_ir_tdo, seen);
			stat_i = rows[i].stat;
			scan(1'b0, rows[i].wdata, rows[i].dr_len, ~rows[i].stat, seen);
			check_value("tdo_o", rows[i].exp_tdo, seen);
			check_value("cfg_o", {32'h0, rows[i].exp_cfg}, {32'h0, cfg_o});
		end

		// Five TMS-high cycles from inside Shift-DR
		scan(1'b1, {60'h0, jtag_pkg::OP_CFG_RD}, 4, stat_i, seen);
		tck_step(1'b1);
		tck_step(1'b0);
		tck_step(1'b0);
		repeat (3) tck_step(1'b0);
		repeat (5) tck_step(1'b1);
		wait_tdo_en(1'b0);
		check_value("cfg_o", {32'h0, cfg_default}, {32'h0, cfg_o});
		tck_step(1'b0);
		scan(1'b0, {$urandom, $urandom}, 32, stat_i, seen);
		check_value("tdo_o", {32'h0, jtag_pkg::IDCODE_VALUE}, seen);

		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

// ==== logic/jtag.sv ====
`default_nettype none
`timescale 1ns/100ps

module jtag (
	input wire logic clk,
	input wire logic arst_n_i,
	input wire logic tck_i,
	input wire logic tms_i,
	input wire logic tdi_i,
	input wire logic trst_n_i,
	output logic tdo_o,
	output logic tdo_en_o,
	input wire dbg_pkg::dbg_stat_t stat_i,
	output dbg_pkg::dbg_cfg_t cfg_o
);
	jtag_pkg::tap_ctrl_t ctrl;
	jtag_pkg::jtag_op_e op;
	logic tdi_sync;
	logic scan_full_ir;
	logic scan_full_dr;
	logic ir_tdo;

	jtag_tap_fsm u_tap_fsm (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.tck_i    (tck_i),
		.tms_i    (tms_i),
		.tdi_i    (tdi_i),
		.trst_n_i (trst_n_i),
		.ctrl_o   (ctrl),
		.tdi_o    (tdi_sync)
	);

	jtag_bit_counter u_bit_counter (
		.clk       (clk),
		.arst_n_i  (arst_n_i),
		.ctrl_i    (ctrl),
		.full_ir_o (scan_full_ir),
		.full_dr_o (scan_full_dr)
	);

	jtag_ir u_ir (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.ctrl_i   (ctrl),
		.tdi_i    (tdi_sync),
		.full_i   (scan_full_ir),
		.op_o     (op),
		.tdo_o    (ir_tdo)
	);

	jtag_dr_bank u_dr_bank (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.ctrl_i   (ctrl),
		.tdi_i    (tdi_sync),
		.op_i     (op),
		.ir_tdo_i (ir_tdo),
		.full_i   (scan_full_dr),
		.stat_i   (stat_i),
		.cfg_o    (cfg_o),
		.tdo_o    (tdo_o),
		.tdo_en_o (tdo_en_o)
	);

endmodule

`default_nettype wire

// ==== logic/jtag_dr_bank.sv ====
`default_nettype none
`timescale 1ns/100ps

module jtag_dr_bank (
	input wire logic clk,
	input wire logic arst_n_i,
	input wire jtag_pkg::tap_ctrl_t ctrl_i,
	input wire logic tdi_i,
	input wire jtag_pkg::jtag_op_e op_i,
	input wire logic ir_tdo_i,
	input wire logic full_i,
	input wire dbg_pkg::dbg_stat_t stat_i,
	output dbg_pkg::dbg_cfg_t cfg_o,
	output logic tdo_o,
	output logic tdo_en_o
);
	logic [jtag_pkg::DR_WIDTH-1:0] sr_q;
	logic bypass_q;
	dbg_pkg::dbg_cfg_t cfg_q;
	logic sel_ir_q;
	logic dr_lsb;

	// Shared data shift path, bypass keeps its own single bit
	always_ff @(posedge clk) begin
		if (ctrl_i.capture_dr) begin
			bypass_q <= 1'b0;
			case (op_i)
				jtag_pkg::OP_IDCODE:  sr_q <= jtag_pkg::IDCODE_VALUE;
				jtag_pkg::OP_CFG_WR:  sr_q <= cfg_q;
				jtag_pkg::OP_CFG_RD:  sr_q <= cfg_q;
				jtag_pkg::OP_STAT_RD: sr_q <= stat_i;
				default:              sr_q <= '0;
			endcase
		end else if (ctrl_i.shift_dr) begin
			bypass_q <= tdi_i;
			sr_q <= {tdi_i, sr_q[jtag_pkg::DR_WIDTH-1:1]};
		end
	end

	// Commit only on an exact-length scan
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cfg_q <= dbg_pkg::CFG_RESET;
		end else if (ctrl_i.in_reset) begin
			cfg_q <= dbg_pkg::CFG_RESET;
		end else if (ctrl_i.update_dr && full_i && (op_i == jtag_pkg::OP_CFG_WR)) begin
			cfg_q <= dbg_pkg::dbg_cfg_t'(sr_q);
		end
	end

	assign cfg_o = cfg_q;

	// Remembers whether the last capture was IR or DR
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			sel_ir_q <= 1'b0;
		end else if (ctrl_i.capture_ir) begin
			sel_ir_q <= 1'b1;
		end else if (ctrl_i.capture_dr) begin
			sel_ir_q <= 1'b0;
		end
	end

	assign dr_lsb = (op_i == jtag_pkg::OP_BYPASS) ? bypass_q : sr_q[0];

	// TDO launched on the falling edge of tck
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			tdo_o <= 1'b0;
			tdo_en_o <= 1'b0;
		end else if (ctrl_i.tck_fall) begin
			tdo_en_o <= ctrl_i.shifting;
			if (ctrl_i.shifting) begin
				tdo_o <= sel_ir_q ? ir_tdo_i : dr_lsb;
			end else begin
				tdo_o <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/jtag_ir.sv ====
`default_nettype none
`timescale 1ns/100ps

module jtag_ir (
	input wire logic clk,
	input wire logic arst_n_i,
	input wire jtag_pkg::tap_ctrl_t ctrl_i,
	input wire logic tdi_i,
	input wire logic full_i,
	output jtag_pkg::jtag_op_e op_o,
	output logic tdo_o
);
	logic [jtag_pkg::IR_WIDTH-1:0] sr_q;

	function automatic jtag_pkg::jtag_op_e decode_op(input logic [jtag_pkg::IR_WIDTH-1:0] code);
		jtag_pkg::jtag_op_e op;
		case (code)
			jtag_pkg::OP_IDCODE:  op = jtag_pkg::OP_IDCODE;
			jtag_pkg::OP_CFG_WR:  op = jtag_pkg::OP_CFG_WR;
			jtag_pkg::OP_CFG_RD:  op = jtag_pkg::OP_CFG_RD;
			jtag_pkg::OP_STAT_RD: op = jtag_pkg::OP_STAT_RD;
			default:              op = jtag_pkg::OP_BYPASS;
		endcase
		return op;
	endfunction

	// Capture pattern ends in 01 per 1149.1
	always_ff @(posedge clk) begin
		if (ctrl_i.capture_ir) begin
			sr_q <= 4'b0001;
		end else if (ctrl_i.shift_ir) begin
			sr_q <= {tdi_i, sr_q[jtag_pkg::IR_WIDTH-1:1]};
		end
	end

	// Truncated IR scans keep the previous instruction
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			op_o <= jtag_pkg::OP_IDCODE;
		end else if (ctrl_i.in_reset) begin
			op_o <= jtag_pkg::OP_IDCODE;
		end else if (ctrl_i.update_ir && full_i) begin
			op_o <= decode_op(sr_q);
		end
	end

	assign tdo_o = sr_q[0];

endmodule

`default_nettype wire

// ==== logic/jtag_bit_counter.sv ====
`default_nettype none
`timescale 1ns/100ps

module jtag_bit_counter (
	input wire logic clk,
	input wire logic arst_n_i,
	input wire jtag_pkg::tap_ctrl_t ctrl_i,
	output logic full_ir_o,
	output logic full_dr_o
);
	logic [jtag_pkg::CNT_WIDTH-1:0] cnt_q;
	logic clear;
	logic step;

	assign clear = ctrl_i.capture_ir || ctrl_i.capture_dr || ctrl_i.in_reset;
	assign step  = ctrl_i.shift_ir || ctrl_i.shift_dr;

	// Saturates so that overlong scans never wrap back to a valid length
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cnt_q <= '0;
		end else if (clear) begin
			cnt_q <= '0;
		end else if (step && (cnt_q != '1)) begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	assign full_ir_o = (cnt_q == jtag_pkg::CNT_WIDTH'(jtag_pkg::IR_WIDTH));
	assign full_dr_o = (cnt_q == jtag_pkg::CNT_WIDTH'(jtag_pkg::DR_WIDTH));

endmodule

`default_nettype wire

// ==== logic/jtag_tap_fsm.sv ====
`default_nettype none
`timescale 1ns/100ps

module jtag_tap_fsm (
	input wire logic clk,
	input wire logic arst_n_i,
	input wire logic tck_i,
	input wire logic tms_i,
	input wire logic tdi_i,
	input wire logic trst_n_i,
	output jtag_pkg::tap_ctrl_t ctrl_o,
	output logic tdi_o
);
	logic [2:0] tck_q;
	logic [1:0] tms_q;
	logic [1:0] tdi_q;
	logic [1:0] trst_n_q;
	logic tck_rise_q;
	logic tck_fall_q;
	jtag_pkg::tap_state_e state_q;
	jtag_pkg::tap_state_e state_d;

	// Pin synchronizers, third tck stage is edge history
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			tck_q <= '0;
			tms_q <= '1;
			tdi_q <= '0;
			trst_n_q <= '0;
			tck_rise_q <= 1'b0;
			tck_fall_q <= 1'b0;
		end else begin
			tck_q <= {tck_q[1:0], tck_i};
			tms_q <= {tms_q[0], tms_i};
			tdi_q <= {tdi_q[0], tdi_i};
			trst_n_q <= {trst_n_q[0], trst_n_i};
			tck_rise_q <= tck_q[1] & ~tck_q[2];
			tck_fall_q <= ~tck_q[1] & tck_q[2];
		end
	end

	always_comb begin
		state_d = state_q;
		unique case (state_q)
			jtag_pkg::TEST_LOGIC_RESET: state_d = tms_q[1] ? jtag_pkg::TEST_LOGIC_RESET : jtag_pkg::RUN_TEST_IDLE;
			jtag_pkg::RUN_TEST_IDLE:    state_d = tms_q[1] ? jtag_pkg::SELECT_DR : jtag_pkg::RUN_TEST_IDLE;
			jtag_pkg::SELECT_DR:        state_d = tms_q[1] ? jtag_pkg::SELECT_IR : jtag_pkg::CAPTURE_DR;
			jtag_pkg::CAPTURE_DR:       state_d = tms_q[1] ? jtag_pkg::EXIT1_DR : jtag_pkg::SHIFT_DR;
			jtag_pkg::SHIFT_DR:         state_d = tms_q[1] ? jtag_pkg::EXIT1_DR : jtag_pkg::SHIFT_DR;
			jtag_pkg::EXIT1_DR:         state_d = tms_q[1] ? jtag_pkg::UPDATE_DR : jtag_pkg::PAUSE_DR;
			jtag_pkg::PAUSE_DR:         state_d = tms_q[1] ? jtag_pkg::EXIT2_DR : jtag_pkg::PAUSE_DR;
			jtag_pkg::EXIT2_DR:         state_d = tms_q[1] ? jtag_pkg::UPDATE_DR : jtag_pkg::SHIFT_DR;
			jtag_pkg::UPDATE_DR:        state_d = tms_q[1] ? jtag_pkg::SELECT_DR : jtag_pkg::RUN_TEST_IDLE;
			jtag_pkg::SELECT_IR:        state_d = tms_q[1] ? jtag_pkg::TEST_LOGIC_RESET : jtag_pkg::CAPTURE_IR;
			jtag_pkg::CAPTURE_IR:       state_d = tms_q[1] ? jtag_pkg::EXIT1_IR : jtag_pkg::SHIFT_IR;
			jtag_pkg::SHIFT_IR:         state_d = tms_q[1] ? jtag_pkg::EXIT1_IR : jtag_pkg::SHIFT_IR;
			jtag_pkg::EXIT1_IR:         state_d = tms_q[1] ? jtag_pkg::UPDATE_IR : jtag_pkg::PAUSE_IR;
			jtag_pkg::PAUSE_IR:         state_d = tms_q[1] ? jtag_pkg::EXIT2_IR : jtag_pkg::PAUSE_IR;
			jtag_pkg::EXIT2_IR:         state_d = tms_q[1] ? jtag_pkg::UPDATE_IR : jtag_pkg::SHIFT_IR;
			jtag_pkg::UPDATE_IR:        state_d = tms_q[1] ? jtag_pkg::SELECT_DR : jtag_pkg::RUN_TEST_IDLE;
			default:                    state_d = jtag_pkg::TEST_LOGIC_RESET;
		endcase
	end

	// TRST overrides any tck activity
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= jtag_pkg::TEST_LOGIC_RESET;
		end else if (!trst_n_q[1]) begin
			state_q <= jtag_pkg::TEST_LOGIC_RESET;
		end else if (tck_rise_q) begin
			state_q <= state_d;
		end
	end

	always_comb begin
		ctrl_o.capture_ir = tck_rise_q && (state_q == jtag_pkg::CAPTURE_IR);
		ctrl_o.shift_ir   = tck_rise_q && (state_q == jtag_pkg::SHIFT_IR);
		ctrl_o.update_ir  = tck_rise_q && (state_q == jtag_pkg::UPDATE_IR);
		ctrl_o.capture_dr = tck_rise_q && (state_q == jtag_pkg::CAPTURE_DR);
		ctrl_o.shift_dr   = tck_rise_q && (state_q == jtag_pkg::SHIFT_DR);
		ctrl_o.update_dr  = tck_rise_q && (state_q == jtag_pkg::UPDATE_DR);
		ctrl_o.tck_fall   = tck_fall_q;
		ctrl_o.in_reset   = (state_q == jtag_pkg::TEST_LOGIC_RESET);
		ctrl_o.shifting   = (state_q == jtag_pkg::SHIFT_IR) || (state_q == jtag_pkg::SHIFT_DR);
	end

	assign tdi_o = tdi_q[1];

endmodule

`default_nettype wire

// ==== logic/dbg_pkg.sv ====
`default_nettype none

package dbg_pkg;

	// Controls for the CDR core, resets are active low
	typedef struct packed {
		logic        int_rstb;
		logic        cdr_rstb;
		logic        sram_rstb;
		logic        en_freq_est;
		logic [3:0]  ki;
		logic [3:0]  kp;
		logic [3:0]  ndiv_clk_cdr;
		logic [15:0] pd_offset_ext;
	} dbg_cfg_t;

	typedef struct packed {
		logic [15:0] phase_est;
		logic [15:0] freq_est;
	} dbg_stat_t;

	// All cores held in reset, default loop gains
	localparam dbg_cfg_t CFG_RESET = '{
		int_rstb:      1'b0,
		cdr_rstb:      1'b0,
		sram_rstb:     1'b0,
		en_freq_est:   1'b0,
		ki:            4'd2,
		kp:            4'd4,
		ndiv_clk_cdr:  4'd0,
		pd_offset_ext: 16'd0
	};

endpackage

`default_nettype wire

// ==== logic/jtag_pkg.sv ====
`default_nettype none

package jtag_pkg;

	localparam int IR_WIDTH  = 4;
	localparam int DR_WIDTH  = 32;
	localparam int CNT_WIDTH = 6;

	// Bit 0 set as required for an IEEE 1149.1 identifier
	localparam logic [DR_WIDTH-1:0] IDCODE_VALUE = 32'h4A2B_C0D1;

	typedef enum logic [3:0] {
		TEST_LOGIC_RESET,
		RUN_TEST_IDLE,
		SELECT_DR,
		CAPTURE_DR,
		SHIFT_DR,
		EXIT1_DR,
		PAUSE_DR,
		EXIT2_DR,
		UPDATE_DR,
		SELECT_IR,
		CAPTURE_IR,
		SHIFT_IR,
		EXIT1_IR,
		PAUSE_IR,
		EXIT2_IR,
		UPDATE_IR
	} tap_state_e;

	// Codes not listed here decode to OP_BYPASS
	typedef enum logic [IR_WIDTH-1:0] {
		OP_IDCODE  = 4'b0001,
		OP_CFG_WR  = 4'b0010,
		OP_CFG_RD  = 4'b0011,
		OP_STAT_RD = 4'b0100,
		OP_BYPASS  = 4'b1111
	} jtag_op_e;

	typedef struct packed {
		logic capture_ir;
		logic shift_ir;
		logic update_ir;
		logic capture_dr;
		logic shift_dr;
		logic update_dr;
		logic tck_fall;
		logic in_reset;
		logic shifting;
	} tap_ctrl_t;

endpackage

`default_nettype wire
